// File: flist.f
+incdir+.
spi_pu_pkg.sv
bounce_filter.sv
word_buffer.sv
tx_path.sv
rx_path.sv
spi_slave_driver.sv
pu_slave_spi.sv
pu_slave_spi_props.sv
tb_pu_slave_spi.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pu_slave_spi
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_pu_slave_spi.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module tb_pu_slave_spi
    import spi_pu_pkg::*;
    ();

    localparam int half_period  = 50;
    localparam int glitch_start = 30;
    localparam int glitch_len   = `SPI_PU_FILTER_DEPTH / 2;
    localparam int idle_gap     = 100;
    localparam int stop_timeout = 4 * `SPI_PU_FILTER_DEPTH;
    localparam int buf_size     = `SPI_PU_BUF_SIZE;
    // three frames of 16, 10 and 28 bytes
    localparam int frame_cnt    = 3;
    localparam int frame_bytes  = 16 + 10 + 28;
    localparam int watchdog_cycles = frame_bytes * 16 * half_period + frame_cnt * 1000 + 5000;

    logic        clk = 1'b0;
    logic        rst;
    logic        signal_cycle;
    logic        signal_wr;
    word_t       data_in;
    logic        signal_oe;
    word_t       data_out;
    logic        flag_stop;
    logic        cs;
    logic        sclk;
    logic        mosi;
    logic        miso;

    // reference model state
    logic [31:0] rng_state = 32'd73;
    logic        sel_model = 1'b0;
    word_t       tx_q [2][$];
    word_t       rx_q [2][$];
    int          stop_cnt  = 0;

    always #2 clk = ~clk;

    pu_slave_spi u_dut
        ( .clk          (clk)
        , .rst          (rst)
        , .signal_cycle (signal_cycle)
        , .signal_wr    (signal_wr)
        , .data_in      (data_in)
        , .signal_oe    (signal_oe)
        , .data_out     (data_out)
        , .flag_stop    (flag_stop)
        , .cs           (cs)
        , .sclk         (sclk)
        , .mosi         (mosi)
        , .miso         (miso)
        );

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            report_failure($sformatf("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
        end
    endtask

    // host side, each strobe lasts one cycle
    task automatic host_write(input word_t w);
        @(posedge clk);
        signal_wr <= 1'b1;
        data_in   <= w;
        @(posedge clk);
        signal_wr <= 1'b0;
        if (tx_q[sel_model].size() < buf_size) begin
            tx_q[sel_model].push_back(w);
        end
    endtask

    task automatic host_swap();
        @(posedge clk);
        signal_cycle <= 1'b1;
        @(posedge clk);
        signal_cycle <= 1'b0;
        sel_model = ~sel_model;
        // new spi-facing receive bank starts empty
        rx_q[~sel_model].delete();
    endtask

    task automatic host_pop();
        word_t got;
        word_t exp;
        @(posedge clk);
        signal_oe <= 1'b1;
        @(posedge clk);
        got = data_out;
        signal_oe <= 1'b0;
        exp = (rx_q[sel_model].size() != 0) ? rx_q[sel_model].pop_front() : '0;
        check_value("data_out", got, exp);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // spi master, mode 0
    ////////////////////////////////////////////////////////////////////////

    // low half of an sclk period, optionally with a strobe or a short sclk spike
    task automatic hold_low_phase(input bit glitch, input bit strobe);
        int left;
        left = half_period;
        if (strobe) begin
            signal_cycle <= 1'b1;
            @(posedge clk);
            signal_cycle <= 1'b0;
            left = left - 1;
        end
        if (glitch) begin
            repeat (glitch_start) @(posedge clk);
            sclk <= 1'b1;
            repeat (glitch_len) @(posedge clk);
            sclk <= 1'b0;
            left = left - glitch_start - glitch_len;
        end
        repeat (left) @(posedge clk);
    endtask

    task automatic run_frame(input int n_bytes, input int strobe_byte, input int glitch_byte);
        int        spi_side;
        int        b;
        int        i;
        int        stops_before;
        int        waited;
        int        rx_cnt;
        word_t     rx_acc;
        word_t     exp_word;
        spi_byte_t exp_byte;
        spi_byte_t mosi_byte;
        spi_byte_t miso_byte;
        spi_side     = sel_model ? 0 : 1;
        stops_before = stop_cnt;
        rx_cnt       = 0;
        rx_acc       = '0;
        miso_byte    = '0;
        @(posedge clk);
        cs <= 1'b0;
        for (b = 0; b < n_bytes; b++) begin
            mosi_byte = spi_byte_t'(next_random());
            // words go out msb first, then zero bytes once the bank runs dry
            if (b / 4 < tx_q[spi_side].size()) begin
                exp_word = tx_q[spi_side][b / 4];
                exp_byte = exp_word[(3 - b % 4) * 8 +: 8];
            end else begin
                exp_byte = '0;
            end
            for (i = 7; i >= 0; i--) begin
                mosi <= mosi_byte[i];
                hold_low_phase(b == glitch_byte && i == 3, b == strobe_byte && i == 7);
                miso_byte[i] = miso;
                sclk <= 1'b1;
                repeat (half_period) @(posedge clk);
                sclk <= 1'b0;
            end
            check_value("miso byte", word_t'(miso_byte), word_t'(exp_byte));
            rx_acc = {rx_acc[23:0], mosi_byte};
            rx_cnt++;
            if (rx_cnt == 4) begin
                if (rx_q[spi_side].size() < buf_size) begin
                    rx_q[spi_side].push_back(rx_acc);
                end
                rx_cnt = 0;
            end
        end
        mosi <= 1'b0;
        repeat (half_period) @(posedge clk);
        cs <= 1'b1;
        waited = 0;
        while (stop_cnt == stops_before && waited < stop_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (stop_cnt == stops_before) begin
            report_failure("flag_stop did not pulse after cs was released");
        end
        repeat (idle_gap) @(posedge clk);
        check_value("flag_stop count", word_t'(stop_cnt), word_t'(stops_before + 1));
        // end of frame flushes the spi-facing transmit bank
        tx_q[spi_side].delete();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // monitors and watchdog
    ////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (flag_stop) begin
            stop_cnt <= stop_cnt + 1;
        end
    end

    always @(posedge clk) begin
        if (u_dut.u_props.err_cnt != 0) begin
            report_failure("a bound assertion on the DUT ports failed");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        rst          <= 1'b1;
        signal_cycle <= 1'b0;
        signal_wr    <= 1'b0;
        data_in      <= '0;
        signal_oe    <= 1'b0;
        cs           <= 1'b1;
        sclk         <= 1'b0;
        mosi         <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("flag_stop", word_t'(flag_stop), '0);
        check_value("miso", word_t'(miso), '0);
        check_value("data_out", data_out, '0);
        // let the filters settle on the idle lines
        repeat (idle_gap) @(posedge clk);

        // transmit three words, receive four
        repeat (3) host_write(next_random());
        host_swap();
        run_frame(16, -1, -1);

        // partial word and a strobe while cs is low
        repeat (3) host_write(next_random());
        host_swap();
        repeat (2) host_pop();
        run_frame(10, 1, -1);
        host_pop();
        host_swap();
        repeat (3) host_pop();

        // overfilled banks and an sclk spike
        repeat (8) host_write(next_random());
        host_swap();
        // leftover word went away when this bank faced the spi side
        host_pop();
        run_frame(28, -1, 5);
        host_swap();
        repeat (7) host_pop();

        repeat (idle_gap) @(posedge clk);
        if (u_dut.u_props.err_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            report_failure("a bound assertion on the DUT ports failed");
        end
    end

endmodule

`default_nettype wire

// File: pu_slave_spi_props.sv
`timescale 1ns/100ps
`default_nettype none

module pu_slave_spi_props
    import spi_pu_pkg::*;
    ( input logic  clk
    , input logic  rst
    , input logic  signal_oe
    , input word_t data_out
    , input logic  flag_stop
    , input logic  miso
    );

    // failures so far, polled by the testbench
    int unsigned err_cnt = 0;

    ////////////////////////////////////////////////////////////////////////
    // port properties
    ////////////////////////////////////////////////////////////////////////

    // stop is a single-cycle pulse
    stop_single_cycle: assert property (
        @(posedge clk) disable iff (rst) flag_stop |=> !flag_stop
    ) else begin
        err_cnt++;
        $error("flag_stop stayed high for two cycles");
    end

    // read port only drives data during a pop
    data_out_idle_zero: assert property (
        @(posedge clk) disable iff (rst) !signal_oe |-> (data_out == '0)
    ) else begin
        err_cnt++;
        $error("data_out nonzero while signal_oe is low");
    end

    outputs_low_after_reset: assert property (
        @(posedge clk) rst |=> (!flag_stop && !miso && (data_out == '0))
    ) else begin
        err_cnt++;
        $error("outputs not low after reset");
    end

endmodule

bind pu_slave_spi pu_slave_spi_props u_props
    ( .clk       (clk)
    , .rst       (rst)
    , .signal_oe (signal_oe)
    , .data_out  (data_out)
    , .flag_stop (flag_stop)
    , .miso      (miso)
    );

`default_nettype wire

// File: pu_slave_spi.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module pu_slave_spi
    import spi_pu_pkg::*;
    ( input  logic  clk
    , input  logic  rst
    , input  logic  signal_cycle
    , input  logic  signal_wr
    , input  word_t data_in
    , input  logic  signal_oe
    , output word_t data_out
    , output logic  flag_stop
    , input  logic  cs
    , input  logic  sclk
    , input  logic  mosi
    , output logic  miso
    );

    logic      f_cs;
    logic      f_sclk;
    logic      f_mosi;
    logic      prev_f_cs;
    logic      frame_end;
    logic      bank_sel;
    logic      tx_byte_req;
    spi_byte_t tx_byte;
    logic      rx_byte_valid;
    spi_byte_t rx_byte;

    ////////////////////////////////////////////////////////////////////////
    // input filters
    ////////////////////////////////////////////////////////////////////////

    bounce_filter #(.depth(`SPI_PU_FILTER_DEPTH)) u_cs_filter
        (.clk(clk), .rst(rst), .raw(cs), .filtered(f_cs));
    bounce_filter #(.depth(`SPI_PU_FILTER_DEPTH)) u_sclk_filter
        (.clk(clk), .rst(rst), .raw(sclk), .filtered(f_sclk));
    bounce_filter #(.depth(`SPI_PU_FILTER_DEPTH)) u_mosi_filter
        (.clk(clk), .rst(rst), .raw(mosi), .filtered(f_mosi));

    ////////////////////////////////////////////////////////////////////////
    // frame control
    ////////////////////////////////////////////////////////////////////////

    // stop pulse on cs release
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_f_cs <= 1'b1;
            frame_end <= 1'b0;
        end else begin
            prev_f_cs <= f_cs;
            frame_end <= f_cs & ~prev_f_cs;
        end
    end

    assign flag_stop = frame_end;

    // swap only while the bus is idle
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_sel <= 1'b0;
        end else if (signal_cycle && f_cs) begin
            bank_sel <= ~bank_sel;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////

    tx_path u_tx_path
        ( .clk         (clk)
        , .rst         (rst)
        , .bank_sel    (bank_sel)
        , .frame_end   (frame_end)
        , .signal_wr   (signal_wr)
        , .data_in     (data_in)
        , .tx_byte_req (tx_byte_req)
        , .tx_byte     (tx_byte)
        );

    rx_path u_rx_path
        ( .clk           (clk)
        , .rst           (rst)
        , .bank_sel      (bank_sel)
        , .frame_end     (frame_end)
        , .rx_byte_valid (rx_byte_valid)
        , .rx_byte       (rx_byte)
        , .signal_oe     (signal_oe)
        , .data_out      (data_out)
        );

    spi_slave_driver u_driver
        ( .clk           (clk)
        , .rst           (rst)
        , .f_cs          (f_cs)
        , .f_sclk        (f_sclk)
        , .f_mosi        (f_mosi)
        , .miso          (miso)
        , .tx_byte_req   (tx_byte_req)
        , .tx_byte       (tx_byte)
        , .rx_byte_valid (rx_byte_valid)
        , .rx_byte       (rx_byte)
        );

endmodule

`default_nettype wire

// File: spi_slave_driver.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module spi_slave_driver
    import spi_pu_pkg::*;
    ( input  logic      clk
    , input  logic      rst
    , input  logic      f_cs
    , input  logic      f_sclk
    , input  logic      f_mosi
    , output logic      miso
    , output logic      tx_byte_req
    , input  spi_byte_t tx_byte
    , output logic      rx_byte_valid
    , output spi_byte_t rx_byte
    );

    spi_state_e state;
    logic       prev_sclk;
    logic       prev_cs;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_fall;
    logic       active;
    logic [2:0] bit_cnt;
    logic [1:0] load_dly;
    logic       next_byte;
    spi_byte_t  tx_shift;
    spi_byte_t  rx_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_sclk <= 1'b0;
            prev_cs   <= 1'b1;
        end else begin
            prev_sclk <= f_sclk;
            prev_cs   <= f_cs;
        end
    end

    assign sclk_rise = f_sclk & ~prev_sclk;
    assign sclk_fall = ~f_sclk & prev_sclk;
    assign cs_fall   = ~f_cs & prev_cs;
    assign active    = (state == st_shift) && !f_cs;

    ////////////////////////////////////////////////////////////////////////
    // frame FSM and byte strobes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= st_idle;
            bit_cnt       <= '0;
            load_dly      <= '0;
            next_byte     <= 1'b0;
            tx_byte_req   <= 1'b0;
            rx_byte_valid <= 1'b0;
        end else begin
            tx_byte_req   <= 1'b0;
            rx_byte_valid <= 1'b0;
            // first byte is loaded two cycles after its request
            load_dly      <= {load_dly[0], cs_fall};
            case (state)
                st_idle: begin
                    if (cs_fall) begin
                        state       <= st_shift;
                        bit_cnt     <= '0;
                        next_byte   <= 1'b0;
                        tx_byte_req <= 1'b1;
                    end
                end
                st_shift: begin
                    if (f_cs) begin
                        state <= st_idle;
                    end else if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            rx_byte_valid <= 1'b1;
                            tx_byte_req   <= 1'b1;
                            next_byte     <= 1'b1;
                        end
                    end else if (sclk_fall) begin
                        next_byte <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // shift registers
    ////////////////////////////////////////////////////////////////////////

    // mode 0: sample on rise, shift out on fall
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            tx_shift <= '0;
        end else if (active) begin
            if (load_dly[1] || (sclk_fall && next_byte)) begin
                tx_shift <= tx_byte;
            end else if (sclk_fall) begin
                tx_shift <= {tx_shift[`SPI_PU_BYTE_WIDTH-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && sclk_rise) begin
            rx_shift <= {rx_shift[`SPI_PU_BYTE_WIDTH-2:0], f_mosi};
        end
    end

    assign rx_byte = rx_shift;
    assign miso    = (state == st_shift) ? tx_shift[`SPI_PU_BYTE_WIDTH-1] : 1'b0;

endmodule

`default_nettype wire

// File: rx_path.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module rx_path
    import spi_pu_pkg::*;
    ( input  logic      clk
    , input  logic      rst
    , input  logic      bank_sel
    , input  logic      frame_end
    , input  logic      rx_byte_valid
    , input  spi_byte_t rx_byte
    , input  logic      signal_oe
    , output word_t     data_out
    );

    localparam int low_w = `SPI_PU_DATA_WIDTH - `SPI_PU_BYTE_WIDTH;

    logic      spi_sel;
    logic      prev_sel;
    logic      swap;
    logic      word_done;
    logic      host_pop;
    logic      [1:0] bank_push;
    logic      [1:0] bank_pop;
    logic      [1:0] bank_clear;
    word_t     bank_head [2];
    buf_cnt_t  bank_cnt [2];
    word_t     acc;
    word_t     next_word;
    byte_idx_t byte_cnt;

    ////////////////////////////////////////////////////////////////////////
    // byte to word assembler
    ////////////////////////////////////////////////////////////////////////

    // first byte ends up in the top of the word
    assign next_word = {acc[low_w-1:0], rx_byte};
    assign word_done = rx_byte_valid && (byte_cnt == 2'd3);

    always_ff @(posedge clk) begin
        if (rx_byte_valid) begin
            acc <= next_word;
        end
    end

    // partial word is lost at the end of a frame
    always_ff @(posedge clk) begin
        if (rst || frame_end) begin
            byte_cnt <= '0;
        end else if (rx_byte_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // bank steering
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_sel <= 1'b0;
        end else begin
            prev_sel <= bank_sel;
        end
    end

    // bank_sel has just flipped, so spi_sel names the new spi bank
    assign swap    = bank_sel ^ prev_sel;
    assign spi_sel = ~bank_sel;

    assign host_pop = signal_oe && (bank_cnt[bank_sel] != '0);

    assign bank_push  = {word_done & spi_sel, word_done & ~spi_sel};
    assign bank_pop   = {host_pop & bank_sel, host_pop & ~bank_sel};
    assign bank_clear = {swap & spi_sel, swap & ~spi_sel};

    for (genvar i = 0; i < 2; i++) begin : g_bank
        word_buffer u_bank
            ( .clk       (clk)
            , .rst       (rst)
            , .clear     (bank_clear[i])
            , .push      (bank_push[i])
            , .push_data (next_word)
            , .pop       (bank_pop[i])
            , .head      (bank_head[i])
            , .count     (bank_cnt[i])
            );
    end

    assign data_out = host_pop ? bank_head[bank_sel] : '0;

endmodule

`default_nettype wire

// File: tx_path.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module tx_path
    import spi_pu_pkg::*;
    ( input  logic      clk
    , input  logic      rst
    , input  logic      bank_sel
    , input  logic      frame_end
    , input  logic      signal_wr
    , input  word_t     data_in
    , input  logic      tx_byte_req
    , output spi_byte_t tx_byte
    );

    logic      spi_sel;
    logic      spi_empty;
    logic      word_done;
    logic      tx_pop;
    logic      [1:0] bank_push;
    logic      [1:0] bank_pop;
    logic      [1:0] bank_clear;
    word_t     bank_head [2];
    buf_cnt_t  bank_cnt [2];
    word_t     spi_head;
    byte_idx_t byte_idx;
    byte_idx_t rev_idx;

    ////////////////////////////////////////////////////////////////////////
    // bank steering
    ////////////////////////////////////////////////////////////////////////

    // host fills bank[bank_sel], the spi side drains the other one
    assign spi_sel   = ~bank_sel;
    assign spi_head  = bank_head[spi_sel];
    assign spi_empty = (bank_cnt[spi_sel] == '0);

    assign word_done = (byte_idx == 2'd3);
    assign tx_pop    = tx_byte_req && !spi_empty && word_done;

    assign bank_push  = {signal_wr & bank_sel, signal_wr & ~bank_sel};
    assign bank_pop   = {tx_pop & spi_sel, tx_pop & ~spi_sel};
    assign bank_clear = {frame_end & spi_sel, frame_end & ~spi_sel};

    for (genvar i = 0; i < 2; i++) begin : g_bank
        word_buffer u_bank
            ( .clk       (clk)
            , .rst       (rst)
            , .clear     (bank_clear[i])
            , .push      (bank_push[i])
            , .push_data (data_in)
            , .pop       (bank_pop[i])
            , .head      (bank_head[i])
            , .count     (bank_cnt[i])
            );
    end

    ////////////////////////////////////////////////////////////////////////
    // word to byte splitter
    ////////////////////////////////////////////////////////////////////////

    // index 0 picks the top byte
    assign rev_idx = ~byte_idx;

    always_ff @(posedge clk) begin
        if (rst || frame_end) begin
            byte_idx <= '0;
        end else if (tx_byte_req && !spi_empty) begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

    // empty bank feeds zero bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_byte <= '0;
        end else if (tx_byte_req) begin
            if (spi_empty) begin
                tx_byte <= '0;
            end else begin
                tx_byte <= spi_head[rev_idx * `SPI_PU_BYTE_WIDTH +: `SPI_PU_BYTE_WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

// File: word_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module word_buffer
    import spi_pu_pkg::*;
    ( input  logic     clk
    , input  logic     rst
    , input  logic     clear
    , input  logic     push
    , input  word_t    push_data
    , input  logic     pop
    , output word_t    head
    , output buf_cnt_t count
    );

    localparam int size = `SPI_PU_BUF_SIZE;

    word_t    mem [size];
    buf_cnt_t wr_ptr;
    buf_cnt_t rd_ptr;
    buf_cnt_t fill;
    logic     do_push;
    logic     do_pop;

    function automatic buf_cnt_t next_ptr(input buf_cnt_t ptr);
        if (ptr == buf_cnt_t'(size - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // full and empty requests are dropped
    assign do_push = push && (fill != buf_cnt_t'(size));
    assign do_pop  = pop && (fill != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign head  = (fill == '0) ? '0 : mem[rd_ptr];
    assign count = fill;

endmodule

`default_nettype wire

// File: bounce_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_pu_consts.svh"

module bounce_filter
    #( parameter int depth = `SPI_PU_FILTER_DEPTH
    )
    ( input  logic clk
    , input  logic rst
    , input  logic raw
    , output logic filtered
    );

    localparam int cnt_w = $clog2(depth + 1);

    logic             sync_1;
    logic             sync_2;
    logic [cnt_w-1:0] stable_cnt;

    // everything idles high so that cs reads as deasserted out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_1     <= 1'b1;
            sync_2     <= 1'b1;
            filtered   <= 1'b1;
            stable_cnt <= '0;
        end else begin
            sync_1 <= raw;
            sync_2 <= sync_1;
            if (sync_2 == filtered) begin
                stable_cnt <= '0;
            end else if (stable_cnt == cnt_w'(depth)) begin
                filtered   <= sync_2;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: spi_pu_pkg.sv
`default_nettype none

`include "spi_pu_consts.svh"

package spi_pu_pkg;

    typedef logic [`SPI_PU_DATA_WIDTH-1:0] word_t;
    typedef logic [`SPI_PU_BYTE_WIDTH-1:0] spi_byte_t;

    // four bytes per word
    typedef logic [1:0] byte_idx_t;

    // fill level 0..6
    typedef logic [2:0] buf_cnt_t;

    typedef enum logic {st_idle, st_shift} spi_state_e;

endpackage

`default_nettype wire

// File: spi_pu_consts.svh
`ifndef SPI_PU_CONSTS_SVH
`define SPI_PU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// widths and depths shared by the package and the RTL
////////////////////////////////////////////////////////////////////////////

// host word
`define SPI_PU_DATA_WIDTH 32

// one spi byte, msb first on the wire
`define SPI_PU_BYTE_WIDTH 8

// words held by each ping-pong bank
`define SPI_PU_BUF_SIZE 6

// cycles an spi input must hold before the filtered line follows
`define SPI_PU_FILTER_DEPTH 20

`endif
